//--- project.f
hw/mosaic_pkg.sv
hw/packet_dispatcher.sv
hw/tile_relay.sv
hw/packet_gatherer.sv
hw/mosaic.sv
verif/tb_clock_gen.sv
verif/tb_mosaic.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mosaic
SEED      ?= 54608
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     ?= project.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -Wno-fatal --top-module $(TOP) -GSEED=$(SEED) \
	  --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^test passed$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_mosaic.sv
// Mosaic fabric testbench

module tb_mosaic
  import mosaic_pkg::*;
#(
  parameter int SEED = 54608
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ROW          = DEF_ROW;
  localparam int COL          = DEF_COL;
  localparam int DRIVE_DLY    = 1;     // Input skew after the rising edge
  localparam int WAIT_LIMIT   = 3000;  // Cycles per wait
  localparam int MAX_LEN      = 12;
  localparam int N_PKTS       = 200;
  localparam int READY_HIGH   = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW    = 2;

  typedef logic [DATA_W+KEEP_W:0] word_t;  // {last, keep, data}

  logic  clk_line, arst_n;
  logic  in_tvalid, in_tready, in_tlast;
  data_t in_tdata;
  keep_t in_tkeep;
  logic  out_tvalid, out_tready, out_tlast;
  data_t out_tdata;
  keep_t out_tkeep;

  word_t exp_q[$];  // Expected egress words, input order
  int    seed;
  int    ready_mode     = READY_HIGH;
  int    cycle_cnt      = 0;
  int    first_in_edge  = -1;
  int    first_out_edge = -1;
  int    pkts_sent      = 0;
  int    pkts_seen      = 0;
  int    mismatch_cnt   = 0;
  int    timeout_cnt    = 0;
  int    fail_cnt       = 0;
  bit    stall_seen     = 1'b0;

  tb_clock_gen #(.PERIOD_NS(40), .RST_CYCLES(4)) clock_gen_inst (.*);

  mosaic #(.ROW(ROW), .COL(COL)) mosaic_inst (.*);

  always @(posedge clk_line) cycle_cnt <= cycle_cnt + 1;

  // Egress back-pressure. Drawn at the falling edge, applied after the rising one
  initial begin
    logic [31:0] rnd;
    logic        nxt;
    out_tready = 1'b1;
    forever begin
      @(negedge clk_line);
      rnd = $random(seed);
      @(posedge clk_line);
      nxt = (ready_mode == READY_HIGH) || (ready_mode == READY_RANDOM && rnd[1:0] != 2'b00);
      #DRIVE_DLY;
      out_tready = nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Egress monitor
  ////////////////////////////////////////////////////////////////////////////

  // Outputs are stable at the falling edge, a transfer follows on the next rise
  always @(negedge clk_line) begin
    word_t got;
    word_t want;
    if (arst_n && out_tvalid && out_tready) begin
      got = {out_tlast, out_tkeep, out_tdata};
      if (first_out_edge < 0) first_out_edge = cycle_cnt + 1;
      if (out_tlast) pkts_seen++;
      if (exp_q.size() == 0) begin
        fail_cnt++;
        $display("ERROR at %0t: egress word %h arrived with nothing outstanding", $time, got);
      end else begin
        want = exp_q.pop_front();
        if (got !== want) begin
          mismatch_cnt++;
          $display("MISMATCH at %0t: last/keep/data %b/%h/%h, expected %b/%h/%h", $time,
                   out_tlast, out_tkeep, out_tdata,
                   want[DATA_W+KEEP_W], want[DATA_W +: KEEP_W], want[DATA_W-1:0]);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_line);
    #DRIVE_DLY;
  endtask

  task automatic report_timeout(input string what);
    timeout_cnt++;
    $display("TIMEOUT at %0t: %s", $time, what);
  endtask

  // Hold one word on the ingress until it is taken
  task automatic send_word(input data_t d, input keep_t k, input logic last);
    int waited;
    waited    = 0;
    in_tvalid = 1'b1;
    in_tdata  = d;
    in_tkeep  = k;
    in_tlast  = last;
    @(negedge clk_line);
    while (!in_tready && timeout_cnt == 0) begin
      if (ready_mode == READY_LOW && !out_tready) begin
        stall_seen = 1'b1;
        ready_mode = READY_RANDOM;  // Fabric backed up, let it drain
      end
      waited++;
      if (waited >= WAIT_LIMIT)
        report_timeout("an ingress word was never accepted");
      else
        @(negedge clk_line);
    end
    if (timeout_cnt == 0) begin
      if (first_in_edge < 0) first_in_edge = cycle_cnt + 1;
      exp_q.push_back({last, k, d});
    end
    next_cycle();
    in_tvalid = 1'b0;
  endtask

  task automatic send_packets(input int count, input int gap_pct);
    logic [31:0] rnd;
    int          len;
    data_t       d;
    for (int p = 0; p < count && timeout_cnt == 0; p++) begin
      rnd = $random(seed);
      len = 1 + int'(rnd % MAX_LEN);
      for (int i = 0; i < len; i++) begin
        rnd = $random(seed);
        if (int'(rnd % 100) < gap_pct) begin
          repeat (1 + int'(rnd[9:8])) next_cycle();  // 1 to 4 idle cycles
        end
        d   = $random(seed);
        rnd = $random(seed);
        send_word(d, rnd[KEEP_W-1:0], i == len - 1);
      end
      pkts_sent++;
    end
  endtask

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && timeout_cnt == 0) begin
      waited++;
      if (waited >= WAIT_LIMIT)
        report_timeout($sformatf("%0d words of %s never arrived", exp_q.size(), what));
      else
        next_cycle();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int waited;
    seed      = SEED;
    in_tvalid = 1'b0;
    in_tdata  = '0;
    in_tkeep  = '0;
    in_tlast  = 1'b0;
    waited    = 0;
    while (arst_n !== 1'b1 && timeout_cnt == 0) begin
      waited++;
      if (waited >= WAIT_LIMIT)
        report_timeout("reset was never released");
      else
        @(posedge clk_line);
    end
    next_cycle();

    // Nothing sent yet, so nothing may leave
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_line);
      if (out_tvalid) begin
        mismatch_cnt++;
        $display("MISMATCH at %0t: out_tvalid high before any word was sent", $time);
      end
    end
    next_cycle();

    send_packets(1, 0);  // Idle fabric, egress always ready
    wait_drain("the single packet");
    if (timeout_cnt == 0 && first_out_edge - first_in_edge != COL) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: first word took %0d cycles, expected %0d", $time,
               first_out_edge - first_in_edge, COL);
    end

    send_packets(60, 0);  // Covers every row several times
    wait_drain("the rotation run");

    ready_mode = READY_LOW;
    send_packets(40, 0);
    if (timeout_cnt == 0 && !stall_seen) begin
      fail_cnt++;
      $display("ERROR at %0t: in_tready never dropped while out_tready was low", $time);
    end
    ready_mode = READY_RANDOM;

    send_packets(N_PKTS - 101, 30);  // Idle gaps plus egress stalls
    wait_drain("the gap run");

    // Nothing further may come out during the drain window
    ready_mode = READY_HIGH;
    repeat (50) next_cycle();
    if (timeout_cnt == 0 && pkts_seen != pkts_sent) begin
      fail_cnt++;
      $display("ERROR at %0t: %0d packets left the fabric but %0d were sent", $time,
               pkts_seen, pkts_sent);
    end

    $display("Errors: %0d mismatches, %0d timeouts, %0d other", mismatch_cnt, timeout_cnt,
             fail_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0 && fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : tb_mosaic

//--- verif/tb_clock_gen.sv
// Testbench clock and reset

module tb_clock_gen #(
  parameter int PERIOD_NS   = 40,  // Line clock period
  parameter int RST_CYCLES  = 4,   // Rising edges with reset held low
  parameter int RELEASE_DLY = 1    // Reset released just after the edge
) (
  output logic clk_line,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_line = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_line = ~clk_line;
    end
  end

  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_line);
    #RELEASE_DLY;
    arst_n = 1'b1;
  end

endmodule : tb_clock_gen

//--- hw/mosaic.sv
// Mosaic packet fabric top

module mosaic
  import mosaic_pkg::*;
#(
  parameter int ROW = DEF_ROW,  // Tile rows
  parameter int COL = DEF_COL   // Tiles per row
) (
  input  logic  clk_line,
  input  logic  arst_n,
  // Ingress stream
  input  logic  in_tvalid,
  output logic  in_tready,
  input  data_t in_tdata,
  input  keep_t in_tkeep,
  input  logic  in_tlast,
  // Egress stream
  output logic  out_tvalid,
  input  logic  out_tready,
  output data_t out_tdata,
  output keep_t out_tkeep,
  output logic  out_tlast
);

  // Links indexed [column boundary][row]. Boundary 0 is the dispatcher
  // side, boundary COL the gatherer side
  logic  [COL:0][ROW-1:0] link_tvalid;
  logic  [COL:0][ROW-1:0] link_tready;
  data_t [COL:0][ROW-1:0] link_tdata;
  keep_t [COL:0][ROW-1:0] link_tkeep;
  logic  [COL:0][ROW-1:0] link_tlast;

  packet_dispatcher #(
    .ROW (ROW)
  ) dispatcher_inst (
    .clk_line   (clk_line),
    .arst_n     (arst_n),
    .in_tvalid  (in_tvalid),
    .in_tready  (in_tready),
    .in_tdata   (in_tdata),
    .in_tkeep   (in_tkeep),
    .in_tlast   (in_tlast),
    .row_tvalid (link_tvalid[0]),
    .row_tready (link_tready[0]),
    .row_tdata  (link_tdata[0]),
    .row_tkeep  (link_tkeep[0]),
    .row_tlast  (link_tlast[0])
  );

  ////////////////////////////////////////////////////////////////////////////
  // Tile grid
  ////////////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < ROW; r++) begin : grid_row
    for (genvar c = 0; c < COL; c++) begin : grid_col
      tile_relay relay_inst (
        .clk_line   (clk_line),
        .arst_n     (arst_n),
        .in_tvalid  (link_tvalid[c][r]),
        .in_tready  (link_tready[c][r]),
        .in_tdata   (link_tdata[c][r]),
        .in_tkeep   (link_tkeep[c][r]),
        .in_tlast   (link_tlast[c][r]),
        .out_tvalid (link_tvalid[c+1][r]),  // Right neighbour or gatherer
        .out_tready (link_tready[c+1][r]),
        .out_tdata  (link_tdata[c+1][r]),
        .out_tkeep  (link_tkeep[c+1][r]),
        .out_tlast  (link_tlast[c+1][r])
      );
    end
  end

  packet_gatherer #(
    .ROW (ROW)
  ) gatherer_inst (
    .clk_line   (clk_line),
    .arst_n     (arst_n),
    .row_tvalid (link_tvalid[COL]),
    .row_tready (link_tready[COL]),
    .row_tdata  (link_tdata[COL]),
    .row_tkeep  (link_tkeep[COL]),
    .row_tlast  (link_tlast[COL]),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready),
    .out_tdata  (out_tdata),
    .out_tkeep  (out_tkeep),
    .out_tlast  (out_tlast)
  );

endmodule : mosaic

//--- hw/packet_gatherer.sv
// Packet gatherer

module packet_gatherer
  import mosaic_pkg::*;
#(
  parameter int ROW = DEF_ROW
) (
  input  logic                clk_line,
  input  logic                arst_n,
  // Right edge of every tile row
  input  logic  [ROW-1:0]     row_tvalid,
  output logic  [ROW-1:0]     row_tready,
  input  data_t [ROW-1:0]     row_tdata,
  input  keep_t [ROW-1:0]     row_tkeep,
  input  logic  [ROW-1:0]     row_tlast,
  // Egress stream
  output logic                out_tvalid,
  input  logic                out_tready,
  output data_t               out_tdata,
  output keep_t               out_tkeep,
  output logic                out_tlast
);

  localparam int ROW_W = (ROW > 1) ? $clog2(ROW) : 1;

  typedef logic [ROW_W-1:0] row_idx_t;

  localparam row_idx_t LAST_ROW = row_idx_t'(ROW - 1);

  row_idx_t exp_ptr;   // Row expected to deliver the next packet
  logic     out_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Egress mux
  ////////////////////////////////////////////////////////////////////////////

  assign out_tvalid = row_tvalid[exp_ptr];
  assign out_tdata  = row_tdata[exp_ptr];
  assign out_tkeep  = row_tkeep[exp_ptr];
  assign out_tlast  = row_tlast[exp_ptr];

  // Other rows hold their words until their turn comes
  always_comb begin
    for (int r = 0; r < ROW; r++) begin
      row_tready[r] = out_tready && (exp_ptr == row_idx_t'(r));
    end
  end

  assign out_fire = out_tvalid && out_tready;

  ////////////////////////////////////////////////////////////////////////////
  // Row rotation
  ////////////////////////////////////////////////////////////////////////////

  // Same order as the dispatcher, which restores arrival order
  always_ff @(posedge clk_line or negedge arst_n) begin
    if (!arst_n) begin
      exp_ptr <= '0;
    end else if (out_fire && out_tlast) begin
      if (exp_ptr == LAST_ROW) begin
        exp_ptr <= '0;
      end else begin
        exp_ptr <= exp_ptr + 1'b1;
      end
    end
  end

endmodule : packet_gatherer

//--- hw/tile_relay.sv
// Tile relay stage

module tile_relay
  import mosaic_pkg::*;
(
  input  logic  clk_line,
  input  logic  arst_n,
  // From the left neighbour
  input  logic  in_tvalid,
  output logic  in_tready,
  input  data_t in_tdata,
  input  keep_t in_tkeep,
  input  logic  in_tlast,
  // To the right neighbour
  output logic  out_tvalid,
  input  logic  out_tready,
  output data_t out_tdata,
  output keep_t out_tkeep,
  output logic  out_tlast
);

  // Second entry, used only while the output entry is stalled
  logic  skid_valid;
  data_t skid_tdata;
  keep_t skid_tkeep;
  logic  skid_tlast;

  logic  push;
  logic  pop;
  logic  out_load;   // Output entry takes a new word this cycle

  // Full means both entries hold a word
  assign in_tready = !skid_valid;

  assign push     = in_tvalid && in_tready;
  assign pop      = out_tvalid && out_tready;
  assign out_load = !out_tvalid || pop;

  ////////////////////////////////////////////////////////////////////////////
  // Occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_line or negedge arst_n) begin
    if (!arst_n) begin
      out_tvalid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_load) begin
      out_tvalid <= skid_valid || push;  // Older word first
      skid_valid <= 1'b0;
    end else if (push) begin
      skid_valid <= 1'b1;                // Output stalled, park the word
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_line) begin
    if (out_load) begin
      if (skid_valid) begin
        out_tdata <= skid_tdata;
        out_tkeep <= skid_tkeep;
        out_tlast <= skid_tlast;
      end else if (push) begin
        out_tdata <= in_tdata;
        out_tkeep <= in_tkeep;
        out_tlast <= in_tlast;
      end
    end else if (push) begin
      skid_tdata <= in_tdata;
      skid_tkeep <= in_tkeep;
      skid_tlast <= in_tlast;
    end
  end

endmodule : tile_relay

//--- hw/packet_dispatcher.sv
// Packet dispatcher

module packet_dispatcher
  import mosaic_pkg::*;
#(
  parameter int ROW = DEF_ROW
) (
  input  logic                clk_line,
  input  logic                arst_n,
  // Ingress stream
  input  logic                in_tvalid,
  output logic                in_tready,
  input  data_t               in_tdata,
  input  keep_t               in_tkeep,
  input  logic                in_tlast,
  // One stream per tile row
  output logic  [ROW-1:0]     row_tvalid,
  input  logic  [ROW-1:0]     row_tready,
  output data_t [ROW-1:0]     row_tdata,
  output keep_t [ROW-1:0]     row_tkeep,
  output logic  [ROW-1:0]     row_tlast
);

  localparam int ROW_W = (ROW > 1) ? $clog2(ROW) : 1;

  typedef logic [ROW_W-1:0] row_idx_t;

  localparam row_idx_t LAST_ROW = row_idx_t'(ROW - 1);

  row_idx_t row_ptr;   // Row that owns the current packet
  logic     in_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Steering
  ////////////////////////////////////////////////////////////////////////////

  // Payload goes to every row, only the selected one sees valid
  assign row_tdata = {ROW{in_tdata}};
  assign row_tkeep = {ROW{in_tkeep}};
  assign row_tlast = {ROW{in_tlast}};

  always_comb begin
    for (int r = 0; r < ROW; r++) begin
      row_tvalid[r] = in_tvalid && (row_ptr == row_idx_t'(r));
    end
  end

  assign in_tready = row_tready[row_ptr];  // Zero latency back-pressure
  assign in_fire   = in_tvalid && in_tready;

  ////////////////////////////////////////////////////////////////////////////
  // Row rotation
  ////////////////////////////////////////////////////////////////////////////

  // Move on only after the tlast word so a packet never splits over rows
  always_ff @(posedge clk_line or negedge arst_n) begin
    if (!arst_n) begin
      row_ptr <= '0;
    end else if (in_fire && in_tlast) begin
      if (row_ptr == LAST_ROW) begin
        row_ptr <= '0;
      end else begin
        row_ptr <= row_ptr + 1'b1;
      end
    end
  end

endmodule : packet_dispatcher

//--- hw/mosaic_pkg.sv
// Mosaic stream fabric definitions

package mosaic_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Stream word geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W = 32;          // Stream data width
  localparam int KEEP_W = DATA_W / 8;  // One enable per byte

  ////////////////////////////////////////////////////////////////////////////
  // Default grid size
  ////////////////////////////////////////////////////////////////////////////

  // Rows share the ingress in rotation, columns set the latency
  localparam int DEF_ROW = 4;  // Tile rows
  localparam int DEF_COL = 3;  // Tiles per row

  ////////////////////////////////////////////////////////////////////////////
  // Word types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [DATA_W-1:0] data_t;  // Stream payload
  typedef logic [KEEP_W-1:0] keep_t;  // Byte enables

endpackage : mosaic_pkg
